// ==== common/mem_map_pkg.sv ====
package mem_map_pkg;

	// bus and bank geometry
	localparam int addr_w     = 16;
	localparam int data_w     = 8;
	localparam int vram_aw    = 13;
	localparam int wram_aw    = 12;
	localparam int hram_aw    = 7;
	localparam int hram_depth = 127;	// FF80 to FFFE as FFFF is IE
	localparam int wram_banks = 8;

	// address windows
	typedef enum logic [3:0] {
		rgn_cart,
		rgn_vram,
		rgn_ext_ram,
		rgn_wram0,
		rgn_wramx,
		rgn_echo,
		rgn_oam,
		rgn_io,
		rgn_hram,
		rgn_ie
	} region_t;

	// special registers inside the io window
	typedef enum logic [1:0] {
		io_none,
		io_if,
		io_vbk,
		io_svbk
	} io_reg_t;

	localparam logic [addr_w-1:0] addr_if   = 16'hff0f;
	localparam logic [addr_w-1:0] addr_vbk  = 16'hff4f;
	localparam logic [addr_w-1:0] addr_svbk = 16'hff70;
	localparam logic [addr_w-1:0] addr_ie   = 16'hffff;

	localparam logic [data_w-1:0] if_reset = 8'h01;	// v-blank pending out of reset
	localparam logic [data_w-1:0] open_bus = 8'hff;
	localparam int num_int = 5;

endpackage

// ==== memory/bank_ram.sv ====
`timescale 1ns/1ns

module bank_ram #(
	parameter int addr_width = 12,
	parameter int depth      = 4096
) (
	input  logic                             core_clk,
	input  logic                             en,
	input  logic                             wr_en,
	input  logic [addr_width-1:0]            addr,
	input  logic [mem_map_pkg::data_w-1:0]   data_in,
	output logic [mem_map_pkg::data_w-1:0]   data_out
);

	logic [mem_map_pkg::data_w-1:0] mem [0:depth-1];

	// read returns the old byte on a write cycle
	always_ff @(posedge core_clk) begin
		if (en) begin
			if (wr_en) begin
				mem[addr] <= data_in;
			end
			data_out <= mem[addr];
		end
	end

endmodule

// ==== memory/ram_banks.sv ====
`timescale 1ns/1ns

module ram_banks #(
	parameter int wram_count = 8
) (
	input  logic                             core_clk,
	input  logic                             addr_bus_we,
	input  logic                             bus_write,
	input  mem_map_pkg::region_t             region,
	input  logic [15:0]                      address_bus_offset,
	input  logic [mem_map_pkg::data_w-1:0]   data_in,
	input  logic                             vram_bank,
	input  logic [2:0]                       wram_bank,
	output logic [mem_map_pkg::data_w-1:0]   vram_q,
	output logic [mem_map_pkg::data_w-1:0]   wram0_q,
	output logic [mem_map_pkg::data_w-1:0]   wramx_q,
	output logic [mem_map_pkg::data_w-1:0]   hram_q
);
	import mem_map_pkg::*;

	logic [data_w-1:0] vram_bank_q [0:1];
	logic [data_w-1:0] wram_bank_q [0:wram_count-1];
	logic [1:0] vram_we;
	logic [wram_count-1:0] wram_we;
	logic [2:0] wram_sel;
	logic hram_we;

	// banks past the last one built clamp to it
	assign wram_sel = (wram_bank < wram_count) ? wram_bank : 3'(wram_count - 1);

	always_comb begin
		vram_we = '0;
		wram_we = '0;
		if (region == rgn_vram) vram_we[vram_bank] = bus_write;
		if (region == rgn_wram0) wram_we[0] = bus_write;
		if (region == rgn_wramx) wram_we[wram_sel] = bus_write;
	end
	assign hram_we = bus_write && (region == rgn_hram);

	// ******************************************************************
	// bank instances all clocked on the address strobe
	// ******************************************************************
	for (genvar b = 0; b < 2; b++) begin : g_vram
		bank_ram #(.addr_width(vram_aw), .depth(1 << vram_aw)) vram_i (
			.core_clk (core_clk),
			.en       (addr_bus_we),
			.wr_en    (vram_we[b]),
			.addr     (address_bus_offset[vram_aw-1:0]),
			.data_in  (data_in),
			.data_out (vram_bank_q[b])
		);
	end

	for (genvar b = 0; b < wram_count; b++) begin : g_wram	// bank 0 fixed at C000
		bank_ram #(.addr_width(wram_aw), .depth(1 << wram_aw)) wram_i (
			.core_clk (core_clk),
			.en       (addr_bus_we),
			.wr_en    (wram_we[b]),
			.addr     (address_bus_offset[wram_aw-1:0]),
			.data_in  (data_in),
			.data_out (wram_bank_q[b])
		);
	end

	bank_ram #(.addr_width(hram_aw), .depth(hram_depth)) hram_i (
		.core_clk (core_clk),
		.en       (addr_bus_we),
		.wr_en    (hram_we),
		.addr     (address_bus_offset[hram_aw-1:0]),
		.data_in  (data_in),
		.data_out (hram_q)
	);

	assign vram_q  = vram_bank_q[vram_bank];
	assign wram0_q = wram_bank_q[0];
	assign wramx_q = wram_bank_q[wram_sel];

endmodule

// ==== verilog/addr_decode.sv ====
`timescale 1ns/1ns

module addr_decode (
	input  logic [mem_map_pkg::addr_w-1:0]   address_bus_in,
	input  logic                             addr_bus_we,
	input  logic                             mem_we,
	output mem_map_pkg::region_t             region,
	output mem_map_pkg::io_reg_t             io_sel,
	output logic [15:0]                      address_bus_offset,
	output logic                             bus_write
);
	import mem_map_pkg::*;

	// window classification and cartridge offset
	always_comb begin
		region = rgn_cart;
		address_bus_offset = address_bus_in;	// 0000-3FFF passes through
		case (address_bus_in[15:12])
			4'h4, 4'h5, 4'h6, 4'h7: begin
				address_bus_offset = address_bus_in - 16'h4000;
			end
			4'h8, 4'h9: begin
				region = rgn_vram;
				address_bus_offset = address_bus_in - 16'h8000;
			end
			4'ha, 4'hb: begin
				region = rgn_ext_ram;
				address_bus_offset = address_bus_in - 16'ha000;
			end
			4'hc: begin
				region = rgn_wram0;
				address_bus_offset = address_bus_in - 16'hc000;
			end
			4'hd: begin
				region = rgn_wramx;
				address_bus_offset = address_bus_in - 16'hd000;
			end
			4'he, 4'hf: begin
				if (address_bus_in < 16'hfe00) begin
					region = rgn_echo;
					address_bus_offset = address_bus_in - 16'h2000;
				end else if (address_bus_in < 16'hfea0) begin
					region = rgn_oam;
					address_bus_offset = address_bus_in - 16'hfe00;
				end else if (address_bus_in < 16'hff00) begin
					region = rgn_oam;	// unusable gap reads like oam
					address_bus_offset = address_bus_in - 16'hfea0;
				end else if (address_bus_in < 16'hff80) begin
					region = rgn_io;
				end else if (address_bus_in != addr_ie) begin
					region = rgn_hram;
					address_bus_offset = address_bus_in - 16'hff80;
				end else begin
					region = rgn_ie;
					address_bus_offset = '0;
				end
			end
			default: ;
		endcase
	end

	always_comb begin
		io_sel = io_none;
		if (region == rgn_io) begin
			if (address_bus_in == addr_if) io_sel = io_if;
			else if (address_bus_in == addr_vbk) io_sel = io_vbk;
			else if (address_bus_in == addr_svbk) io_sel = io_svbk;
		end
	end

	assign bus_write = addr_bus_we && mem_we;

endmodule

// ==== verilog/bank_regs.sv ====
`timescale 1ns/1ns

module bank_regs (
	input  logic                             core_clk,
	input  logic                             reset_n,
	input  mem_map_pkg::io_reg_t             io_sel,
	input  logic                             bus_write,
	input  logic [mem_map_pkg::data_w-1:0]   data_in,
	output logic                             vram_bank,
	output logic [2:0]                       wram_bank,
	output logic [mem_map_pkg::data_w-1:0]   vbk_q,
	output logic [mem_map_pkg::data_w-1:0]   svbk_q
);
	import mem_map_pkg::*;

	logic vbk;
	logic [2:0] svbk;

	always_ff @(posedge core_clk or negedge reset_n) begin
		if (!reset_n) begin
			vbk <= 1'b0;
			svbk <= 3'd0;
		end else if (bus_write) begin
			if (io_sel == io_vbk) vbk <= data_in[0];
			if (io_sel == io_svbk) svbk <= data_in[2:0];
		end
	end

	assign vram_bank = vbk;
	assign wram_bank = (svbk == 3'd0) ? 3'd1 : svbk;	// svbk 0 aliases bank 1

	assign vbk_q  = {{(data_w-1){1'b0}}, vbk};
	assign svbk_q = {{(data_w-3){1'b0}}, svbk};

endmodule

// ==== verilog/int_ctrl.sv ====
`timescale 1ns/1ns

module int_ctrl (
	input  logic                             core_clk,
	input  logic                             reset_n,
	input  mem_map_pkg::io_reg_t             io_sel,
	input  mem_map_pkg::region_t             region,
	input  logic                             bus_write,
	input  logic [mem_map_pkg::data_w-1:0]   data_in,
	input  logic                             ime,
	input  logic                             clear_interrupt,
	input  logic                             v_blank_int_req,
	input  logic                             lcd_stat_int_req,
	input  logic                             timer_int_req,
	input  logic                             serial_int_req,
	input  logic                             joypad_int_req,
	output logic [mem_map_pkg::data_w-1:0]   if_q,
	output logic [mem_map_pkg::data_w-1:0]   ie_q,
	output logic [mem_map_pkg::num_int-1:0]  interrupts
);
	import mem_map_pkg::*;

	logic [num_int-1:0] if_r;
	logic [num_int-1:0] ie_r;
	logic [num_int-1:0] req;
	logic [num_int-1:0] lowest;

	assign req = {joypad_int_req, serial_int_req, timer_int_req,
		lcd_stat_int_req, v_blank_int_req};

	// isolate lowest set flag
	assign lowest = if_r & (~if_r + 1'b1);

	// ******************************************************************
	// IF priority is clear over cpu write over new requests
	// ******************************************************************
	always_ff @(posedge core_clk or negedge reset_n) begin
		if (!reset_n) begin
			if_r <= if_reset[num_int-1:0];
			ie_r <= '0;
		end else begin
			if (clear_interrupt) if_r <= if_r & ~lowest;
			else if (bus_write && (io_sel == io_if)) if_r <= data_in[num_int-1:0];
			else if_r <= if_r | req;

			if (bus_write && (region == rgn_ie)) ie_r <= data_in[num_int-1:0];
		end
	end

	assign if_q = {{(data_w-num_int){1'b0}}, if_r};
	assign ie_q = {{(data_w-num_int){1'b0}}, ie_r};

	assign interrupts = if_r & ie_r & {num_int{ime}};	// bit 0 is v-blank

endmodule

// ==== verilog/read_mux.sv ====
`timescale 1ns/1ns

module read_mux (
	input  logic                             core_clk,
	input  logic                             reset_n,
	input  logic                             addr_bus_we,
	input  mem_map_pkg::region_t             region,
	input  mem_map_pkg::io_reg_t             io_sel,
	input  logic [mem_map_pkg::data_w-1:0]   data_bus_in_ext,
	input  logic [mem_map_pkg::data_w-1:0]   vram_q,
	input  logic [mem_map_pkg::data_w-1:0]   wram0_q,
	input  logic [mem_map_pkg::data_w-1:0]   wramx_q,
	input  logic [mem_map_pkg::data_w-1:0]   hram_q,
	input  logic [mem_map_pkg::data_w-1:0]   vbk_q,
	input  logic [mem_map_pkg::data_w-1:0]   svbk_q,
	input  logic [mem_map_pkg::data_w-1:0]   if_q,
	input  logic [mem_map_pkg::data_w-1:0]   ie_q,
	output logic [mem_map_pkg::data_w-1:0]   data_out
);
	import mem_map_pkg::*;

	region_t region_q;
	io_reg_t io_q;

	// selectors follow the address latch
	always_ff @(posedge core_clk or negedge reset_n) begin
		if (!reset_n) begin
			region_q <= rgn_cart;
			io_q <= io_none;
		end else if (addr_bus_we) begin
			region_q <= region;
			io_q <= io_sel;
		end
	end

	always_comb begin
		case (region_q)
			rgn_cart, rgn_ext_ram: data_out = data_bus_in_ext;
			rgn_vram:  data_out = vram_q;
			rgn_wram0: data_out = wram0_q;
			rgn_wramx: data_out = wramx_q;
			rgn_hram:  data_out = hram_q;
			rgn_ie:    data_out = ie_q;
			rgn_io: begin
				case (io_q)
					io_if:   data_out = if_q;
					io_vbk:  data_out = vbk_q;
					io_svbk: data_out = svbk_q;
					default: data_out = open_bus;	// unused io
				endcase
			end
			default: data_out = open_bus;	// echo and oam
		endcase
	end

endmodule

// ==== verilog/memory_map.sv ====
`timescale 1ns/1ns

module memory_map #(
	parameter int wram_count = mem_map_pkg::wram_banks
) (
	input  logic                             core_clk,
	input  logic                             reset_n,
	input  logic [mem_map_pkg::addr_w-1:0]   address_bus_in,
	input  logic                             addr_bus_we,
	input  logic                             mem_we,
	input  logic [mem_map_pkg::data_w-1:0]   data_in,
	input  logic [mem_map_pkg::data_w-1:0]   data_bus_in_ext,
	input  logic                             ime,
	input  logic                             clear_interrupt,
	input  logic                             v_blank_int_req,
	input  logic                             lcd_stat_int_req,
	input  logic                             timer_int_req,
	input  logic                             serial_int_req,
	input  logic                             joypad_int_req,
	output logic [mem_map_pkg::data_w-1:0]   data_out,
	output logic [15:0]                      address_bus_offset,
	output logic [mem_map_pkg::num_int-1:0]  interrupts
);
	import mem_map_pkg::*;

	region_t region;
	io_reg_t io_sel;
	logic bus_write;
	logic vram_bank;
	logic [2:0] wram_bank;
	logic [data_w-1:0] vbk_q, svbk_q, if_q, ie_q;
	logic [data_w-1:0] vram_q, wram0_q, wramx_q, hram_q;

	addr_decode addr_decode_i (
		.address_bus_in, .addr_bus_we, .mem_we,
		.region, .io_sel, .address_bus_offset, .bus_write
	);

	bank_regs bank_regs_i (
		.core_clk, .reset_n, .io_sel, .bus_write, .data_in,
		.vram_bank, .wram_bank, .vbk_q, .svbk_q
	);

	int_ctrl int_ctrl_i (
		.core_clk, .reset_n, .io_sel, .region, .bus_write, .data_in,
		.ime, .clear_interrupt,
		.v_blank_int_req, .lcd_stat_int_req, .timer_int_req,
		.serial_int_req, .joypad_int_req,
		.if_q, .ie_q, .interrupts
	);

	ram_banks #(.wram_count(wram_count)) ram_banks_i (
		.core_clk, .addr_bus_we, .bus_write, .region, .address_bus_offset,
		.data_in, .vram_bank, .wram_bank,
		.vram_q, .wram0_q, .wramx_q, .hram_q
	);

	read_mux read_mux_i (
		.core_clk, .reset_n, .addr_bus_we, .region, .io_sel, .data_bus_in_ext,
		.vram_q, .wram0_q, .wramx_q, .hram_q,
		.vbk_q, .svbk_q, .if_q, .ie_q,
		.data_out
	);

endmodule

// ==== test/mem_checker.sv ====
`timescale 1ns/1ns

module mem_checker (
	input  logic                             core_clk,
	input  logic                             check_stb,
	input  logic [1:0]                       check_sel,
	input  logic [15:0]                      check_exp,
	input  logic [127:0]                     check_name,
	input  logic                             done,
	input  logic [mem_map_pkg::data_w-1:0]   data_out,
	input  logic [15:0]                      address_bus_offset,
	input  logic [mem_map_pkg::num_int-1:0]  interrupts,
	output int                               check_count,
	output int                               fail_count
);

	logic [15:0] actual;
	string sig_name;
	int checks = 0;
	int fails = 0;

	assign check_count = checks;
	assign fail_count = fails;

	// sample half a cycle after the drive edge
	always @(negedge core_clk) begin
		if (check_stb) begin
			case (check_sel)
				2'd0: begin
					actual = 16'(data_out);
					sig_name = "data_out";
				end
				2'd1: begin
					actual = address_bus_offset;
					sig_name = "address_bus_offset";
				end
				default: begin
					actual = 16'(interrupts);
					sig_name = "interrupts";
				end
			endcase
			checks = checks + 1;
			if (actual !== check_exp) begin
				fails = fails + 1;
				$display("[FAIL] %0t test %0d %s %s expected %h actual %h",
					$time, checks, check_name, sig_name, check_exp, actual);
			end else begin
				$display("[ OK ] test %0d %s %s = %h", checks, check_name, sig_name, actual);
			end
		end
	end

	always @(posedge done) begin
		$display("checks run %0d, passed %0d, failed %0d", checks, checks - fails, fails);
	end

endmodule

// ==== test/tb_top.sv ====
`timescale 1ns/1ns

module tb_top;
	import mem_map_pkg::*;

	typedef enum logic [2:0] {
		op_write,
		op_read,
		op_offset,
		op_request,
		op_clear
	} tb_op_t;

	typedef struct packed {
		tb_op_t op;
		logic [15:0] addr;
		logic [7:0] data;
		logic [15:0] exp;
		logic ime;
		logic [127:0] name;
	} stim_t;

	logic core_clk;
	logic reset_n;
	logic [addr_w-1:0] address_bus_in;
	logic addr_bus_we;
	logic mem_we;
	logic [data_w-1:0] data_in;
	logic [data_w-1:0] data_bus_in_ext;
	logic ime;
	logic clear_interrupt;
	logic v_blank_int_req;
	logic lcd_stat_int_req;
	logic timer_int_req;
	logic serial_int_req;
	logic joypad_int_req;
	logic [data_w-1:0] data_out;
	logic [15:0] address_bus_offset;
	logic [num_int-1:0] interrupts;

	logic check_stb;
	logic [1:0] check_sel;
	logic [15:0] check_exp;
	logic [127:0] check_name;
	logic done;
	int check_count;
	int fail_count;
	int expected_checks = 0;
	int wd;
	integer seed = 32'hd2ec;
	stim_t stim [$];

	// address on top, expected offset below
	logic [31:0] offset_pairs [0:17] = '{
		32'h0123_0123, 32'h3fff_3fff, 32'h4000_0000, 32'h7abc_3abc,
		32'h8100_0100, 32'h9fff_1fff, 32'ha010_0010, 32'hbfff_1fff,
		32'hc045_0045, 32'hd123_0123, 32'he100_c100, 32'hfdff_ddff,
		32'hfe10_0010, 32'hfea5_0005, 32'hff20_ff20, 32'hff90_0010,
		32'hfffe_007e, 32'hffff_0000
	};

	memory_map #(.wram_count(wram_banks)) dut_i (
		.core_clk, .reset_n, .address_bus_in, .addr_bus_we, .mem_we,
		.data_in, .data_bus_in_ext, .ime, .clear_interrupt,
		.v_blank_int_req, .lcd_stat_int_req, .timer_int_req,
		.serial_int_req, .joypad_int_req,
		.data_out, .address_bus_offset, .interrupts
	);

	mem_checker checker_i (
		.core_clk, .check_stb, .check_sel, .check_exp, .check_name, .done,
		.data_out, .address_bus_offset, .interrupts, .check_count, .fail_count
	);

	initial begin
		core_clk = 1'b0;
		forever #10 core_clk = ~core_clk;
	end

	function automatic logic is_ext_window(input logic [15:0] addr);
		return (addr < 16'h8000) || (addr >= 16'ha000 && addr < 16'hc000);
	endfunction

	task automatic push_entry(input tb_op_t op, input logic [15:0] addr,
		input logic [7:0] data, input logic [15:0] exp, input logic ime_v,
		input logic [127:0] name);
		stim_t e;
		e.op = op;
		e.addr = addr;
		e.data = data;
		e.exp = exp;
		e.ime = ime_v;
		e.name = name;
		stim.push_back(e);
		if (op != op_write) expected_checks++;
	endtask

	// ******************************************************************
	// stimulus table
	// ******************************************************************
	task automatic build_table();
		push_entry(op_read, addr_if, 8'h00, 16'h0001, 1'b1, "reset values    ");
		push_entry(op_read, addr_ie, 8'h00, 16'h0000, 1'b1, "reset values    ");
		push_entry(op_read, addr_vbk, 8'h00, 16'h0000, 1'b1, "reset values    ");
		push_entry(op_read, addr_svbk, 8'h00, 16'h0000, 1'b1, "reset values    ");
		push_entry(op_request, 16'h0000, 8'h00, 16'h0000, 1'b1, "reset values    ");

		for (int s = 0; s < 8; s++) begin
			push_entry(op_write, addr_svbk, 8'(s), 16'h0000, 1'b1, "wram banking    ");
			push_entry(op_write, 16'hd123, 8'(8'h10 + s), 16'h0000, 1'b1, "wram banking    ");
		end
		for (int s = 0; s < 8; s++) begin	// svbk 0 and 1 share the byte written last
			push_entry(op_write, addr_svbk, 8'(s), 16'h0000, 1'b1, "wram banking    ");
			push_entry(op_read, 16'hd123, 8'h00, (s < 2) ? 16'h0011 : 16'(16'h10 + s), 1'b1,
				"wram banking    ");
		end
		push_entry(op_read, addr_svbk, 8'h00, 16'h0007, 1'b1, "wram banking    ");
		push_entry(op_write, 16'hc045, 8'h5a, 16'h0000, 1'b1, "wram banking    ");
		push_entry(op_write, addr_svbk, 8'h03, 16'h0000, 1'b1, "wram banking    ");
		push_entry(op_read, 16'hc045, 8'h00, 16'h005a, 1'b1, "wram banking    ");

		push_entry(op_write, addr_vbk, 8'h00, 16'h0000, 1'b1, "vram and hram   ");
		push_entry(op_write, 16'h8100, 8'ha1, 16'h0000, 1'b1, "vram and hram   ");
		push_entry(op_write, addr_vbk, 8'h01, 16'h0000, 1'b1, "vram and hram   ");
		push_entry(op_write, 16'h8100, 8'hb2, 16'h0000, 1'b1, "vram and hram   ");
		push_entry(op_write, addr_vbk, 8'h00, 16'h0000, 1'b1, "vram and hram   ");
		push_entry(op_read, 16'h8100, 8'h00, 16'h00a1, 1'b1, "vram and hram   ");
		push_entry(op_write, addr_vbk, 8'h01, 16'h0000, 1'b1, "vram and hram   ");
		push_entry(op_read, 16'h8100, 8'h00, 16'h00b2, 1'b1, "vram and hram   ");
		push_entry(op_read, addr_vbk, 8'h00, 16'h0001, 1'b1, "vram and hram   ");
		push_entry(op_write, 16'hff90, 8'hc3, 16'h0000, 1'b1, "vram and hram   ");
		push_entry(op_read, 16'hff90, 8'h00, 16'h00c3, 1'b1, "vram and hram   ");
		push_entry(op_read, 16'he100, 8'h00, 16'h00ff, 1'b1, "open bus        ");
		push_entry(op_read, 16'hfe10, 8'h00, 16'h00ff, 1'b1, "open bus        ");
		push_entry(op_read, 16'hff20, 8'h00, 16'h00ff, 1'b1, "open bus        ");
		push_entry(op_read, 16'h1234, 8'h00, 16'h0000, 1'b1, "external bus    ");
		push_entry(op_read, 16'ha010, 8'h00, 16'h0000, 1'b1, "external bus    ");

		for (int i = 0; i < 18; i++) begin
			push_entry(op_offset, offset_pairs[i][31:16], 8'h00, offset_pairs[i][15:0], 1'b1,
				"offsets         ");
		end

		push_entry(op_write, addr_ie, 8'h1f, 16'h0000, 1'b1, "interrupts      ");
		push_entry(op_read, addr_ie, 8'h00, 16'h001f, 1'b1, "interrupts      ");
		push_entry(op_request, 16'h0000, 8'h0c, 16'h000d, 1'b1, "interrupts      ");
		push_entry(op_read, addr_if, 8'h00, 16'h000d, 1'b1, "interrupts      ");
		push_entry(op_clear, 16'h0000, 8'h00, 16'h000c, 1'b1, "interrupts      ");
		push_entry(op_clear, 16'h0000, 8'h00, 16'h0008, 1'b1, "interrupts      ");
		push_entry(op_clear, 16'h0000, 8'h00, 16'h0000, 1'b1, "interrupts      ");
		push_entry(op_request, 16'h0000, 8'h13, 16'h0000, 1'b0, "interrupts      ");
		push_entry(op_read, addr_if, 8'h00, 16'h0013, 1'b0, "interrupts      ");
		push_entry(op_write, addr_if, 8'h04, 16'h0000, 1'b1, "interrupts      ");
		push_entry(op_read, addr_if, 8'h00, 16'h0004, 1'b1, "interrupts      ");
		push_entry(op_request, 16'h0000, 8'h00, 16'h0004, 1'b1, "interrupts      ");
	endtask

	// drive at one edge, DUT acts at the next, check strobe for one cycle
	task automatic apply_entry(input stim_t e);
		logic [31:0] rnd;
		logic [15:0] expected;
		expected = e.exp;
		address_bus_in <= e.addr;
		data_in <= e.data;
		ime <= e.ime;
		case (e.op)
			op_write: begin
				addr_bus_we <= 1'b1;
				mem_we <= 1'b1;
			end
			op_read: begin
				addr_bus_we <= 1'b1;
				if (is_ext_window(e.addr)) begin
					rnd = $random(seed);
					data_bus_in_ext <= rnd[7:0];
					expected = {8'h00, rnd[7:0]};
				end
			end
			op_request: begin
				{joypad_int_req, serial_int_req, timer_int_req, lcd_stat_int_req,
					v_blank_int_req} <= e.data[4:0];
			end
			op_clear: clear_interrupt <= 1'b1;
			default: ;
		endcase
		@(posedge core_clk);
		addr_bus_we <= 1'b0;
		mem_we <= 1'b0;
		clear_interrupt <= 1'b0;
		{joypad_int_req, serial_int_req, timer_int_req, lcd_stat_int_req,
			v_blank_int_req} <= 5'b0;
		if (e.op != op_write) begin
			check_stb <= 1'b1;
			check_sel <= (e.op == op_read) ? 2'd0 : (e.op == op_offset) ? 2'd1 : 2'd2;
			check_exp <= expected;
			check_name <= e.name;
		end
		@(posedge core_clk);
		check_stb <= 1'b0;
	endtask

	initial begin
		reset_n = 1'b0;
		address_bus_in = '0;
		addr_bus_we = 1'b0;
		mem_we = 1'b0;
		data_in = '0;
		data_bus_in_ext = '0;
		ime = 1'b0;
		clear_interrupt = 1'b0;
		v_blank_int_req = 1'b0;
		lcd_stat_int_req = 1'b0;
		timer_int_req = 1'b0;
		serial_int_req = 1'b0;
		joypad_int_req = 1'b0;
		check_stb = 1'b0;
		check_sel = 2'd0;
		check_exp = '0;
		check_name = '0;
		done = 1'b0;
		build_table();
		for (int i = 0; i < 5; i++) @(posedge core_clk);	// 5 cycles in reset
		reset_n <= 1'b1;
		@(posedge core_clk);
		for (int i = 0; i < stim.size(); i++) apply_entry(stim[i]);
		done <= 1'b1;
		@(posedge core_clk);
		@(posedge core_clk);
		if (fail_count == 0 && check_count == expected_checks) begin
			$display("sim passed");
		end else begin
			if (check_count != expected_checks)
				$display("only %0d of %0d checks ran", check_count, expected_checks);
			$display("sim failed");
		end
		$finish;
	end

	// watchdog on the whole table
	initial begin
		for (wd = 0; wd < 1000 && !done; wd++) @(posedge core_clk);
		if (!done) begin
			$display("timeout: stimulus table did not finish within %0d cycles", wd);
			$display("sim failed");
			$finish;
		end
	end

endmodule

// ==== tb.f ====
common/mem_map_pkg.sv
memory/bank_ram.sv
memory/ram_banks.sv
verilog/addr_decode.sv
verilog/bank_regs.sv
verilog/int_ctrl.sv
verilog/read_mux.sv
verilog/memory_map.sv
test/mem_checker.sv
test/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f tb.f --top-module tb_top -Mdir obj_dir -o tb_sim; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
fi
exit 1
